//--- hw/esp_cmd_pkg.sv
`default_nettype none

package esp_cmd_pkg;

  typedef logic [7:0] esp_byte_t;  // one byte on the spi channel

  // numbering kept from the board firmware, gaps belong to dropped functions
  typedef enum logic [7:0] {
    get_cookie          = 8'd0,
    set_breakpoint      = 8'd6,
    clear_breakpoint    = 8'd7,
    enable_breakpoints  = 8'd11,
    disable_breakpoints = 8'd12,
    get_version         = 8'd15,
    abus_read           = 8'd18,
    send_keyb           = 8'd19,
    set_led             = 8'd26
  } esp_opcode_e;

  localparam esp_byte_t COOKIE = 8'haf;  // lets the esp probe for the fpga

  localparam logic [2:0] VERSION_MAJOR = 3'd0;
  localparam logic [4:0] VERSION_MINOR = 5'd3;

  localparam int MAX_PARAMS = 3;  // set_breakpoint takes the most

  typedef logic [1:0] param_idx_t;  // selects a parameter byte

endpackage

`default_nettype wire

//--- hw/trs_bus_pkg.sv
`default_nettype none

package trs_bus_pkg;

  typedef logic [15:0] trs_addr_t;  // z80 address bus

  // keyboard matrix, 8 rows of 8 keys
  typedef logic [7:0] keyb_row_t;
  typedef logic [2:0] keyb_row_idx_t;

endpackage

`default_nettype wire

//--- hw/spi_byte_link.sv
`default_nettype none

module spi_byte_link (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  sck,
  input  logic                  cs_n,
  input  logic                  mosi,
  output logic                  miso,
  input  logic                  tx_load,
  input  esp_cmd_pkg::esp_byte_t tx_byte,
  output esp_cmd_pkg::esp_byte_t rx_byte,
  output logic                  rx_valid,
  output logic                  frame_start
);
  import esp_cmd_pkg::*;

  // two sync flops each, third sck/cs stage for edge detect
  logic [2:0] sck_q;
  logic [2:0] cs_q;
  logic [1:0] mosi_q;

  logic       sck_rise;
  logic       sck_fall;
  logic       cs_active;

  logic [2:0] bit_cnt;   // rising edges within the current byte
  esp_byte_t  rx_shift;

  esp_byte_t  tx_shift;
  logic [3:0] tx_cnt;    // falling edges still to shift
  logic       tx_armed;  // set once a rising edge follows the load
  logic       tx_busy;

  always_ff @(posedge clk) begin
    if (rst) begin
      sck_q <= '0;
      cs_q  <= 3'b111;  // deselected
    end else begin
      sck_q <= {sck_q[1:0], sck};
      cs_q  <= {cs_q[1:0], cs_n};
    end
  end

  always_ff @(posedge clk) begin
    mosi_q <= {mosi_q[0], mosi};
  end

  assign sck_rise  = (sck_q[2:1] == 2'b01);
  assign sck_fall  = (sck_q[2:1] == 2'b10);
  assign cs_active = ~cs_q[1];

  // start of frame, one cycle on the cs_n falling edge
  always_ff @(posedge clk) begin
    if (rst) frame_start <= 1'b0;
    else     frame_start <= cs_q[2] & ~cs_q[1];
  end

  // receive side, msb first, sampled on rising sck
  always_ff @(posedge clk) begin
    if (rst) begin
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= cs_active && sck_rise && (bit_cnt == 3'd7) && !tx_busy;  // dummy bytes dropped
      if (!cs_active)    bit_cnt <= '0;
      else if (sck_rise) bit_cnt <= bit_cnt + 3'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (cs_active && sck_rise) rx_shift <= {rx_shift[6:0], mosi_q[1]};
  end

  assign rx_byte = rx_shift;

  // transmit side
  // the falling edge that ends the command byte must not shift, hence tx_armed
  always_ff @(posedge clk) begin
    if (rst) begin
      tx_shift <= '0;
      tx_cnt   <= '0;
      tx_armed <= 1'b0;
    end else begin
      if (!cs_active) begin
        tx_cnt   <= '0;
        tx_armed <= 1'b0;
      end else if (tx_load) begin
        tx_shift <= tx_byte;  // bit 7 on miso right away
        tx_cnt   <= 4'd8;
        tx_armed <= 1'b0;
      end else begin
        if (sck_rise) tx_armed <= 1'b1;
        if (sck_fall && tx_armed && tx_busy) begin
          tx_shift <= {tx_shift[6:0], 1'b0};
          tx_cnt   <= tx_cnt - 4'd1;
        end
      end
    end
  end

  assign tx_busy = (tx_cnt != 4'd0);

  assign miso = cs_active ? tx_shift[7] : 1'bz;  // released while deselected

endmodule

`default_nettype wire

//--- hw/esp_cmd_parser.sv
`default_nettype none

module esp_cmd_parser (
  input  logic                     clk,
  input  logic                     rst,
  input  esp_cmd_pkg::esp_byte_t   rx_byte,
  input  logic                     rx_valid,
  input  logic                     frame_start,
  input  trs_bus_pkg::trs_addr_t   trs_addr,
  output logic                     action,
  output esp_cmd_pkg::esp_opcode_e opcode,
  output esp_cmd_pkg::esp_byte_t   param0,
  output esp_cmd_pkg::esp_byte_t   param1,
  output esp_cmd_pkg::esp_byte_t   param2,
  output logic                     tx_load,
  output esp_cmd_pkg::esp_byte_t   tx_byte
);
  import esp_cmd_pkg::*;

  typedef enum logic {
    idle,
    read_params
  } state_t;

  state_t      state;
  esp_opcode_e op_in;
  param_idx_t  params_left;  // bytes still to come
  param_idx_t  param_idx;    // next slot to fill
  esp_byte_t   params [MAX_PARAMS];

  // parameter bytes per opcode, zero for the rest
  function automatic param_idx_t param_count(input esp_opcode_e op);
    case (op)
      set_breakpoint:   return param_idx_t'(3);
      clear_breakpoint: return param_idx_t'(1);
      send_keyb:        return param_idx_t'(2);
      set_led:          return param_idx_t'(1);
      default:          return param_idx_t'(0);
    endcase
  endfunction

  assign op_in = esp_opcode_e'(rx_byte);  // may hold a value outside the enum

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= idle;
      action      <= 1'b0;
      tx_load     <= 1'b0;
      params_left <= '0;
      param_idx   <= '0;
    end else begin
      action  <= 1'b0;  // strobes
      tx_load <= 1'b0;
      if (frame_start) begin
        state <= idle;  // new frame always starts with an opcode
      end else if (rx_valid) begin
        case (state)
          idle: begin
            param_idx   <= '0;
            params_left <= param_count(op_in);
            case (op_in)
              get_cookie, get_version, abus_read: begin
                action  <= 1'b1;
                tx_load <= 1'b1;
              end
              enable_breakpoints, disable_breakpoints: begin
                action <= 1'b1;
              end
              set_breakpoint, clear_breakpoint, send_keyb, set_led: begin
                state <= read_params;
              end
              default: begin
                state <= idle;  // unknown, ignored
              end
            endcase
          end
          read_params: begin
            param_idx <= param_idx + param_idx_t'(1);
            if (params_left == param_idx_t'(1)) begin
              action <= 1'b1;  // last parameter in
              state  <= idle;
            end else begin
              params_left <= params_left - param_idx_t'(1);
            end
          end
          default: state <= idle;
        endcase
      end
    end
  end

  // opcode and parameters, payload only
  always_ff @(posedge clk) begin
    if (rx_valid && !frame_start) begin
      if (state == idle) opcode <= op_in;
      else               params[param_idx] <= rx_byte;
    end
  end

  // response byte goes out with tx_load
  always_ff @(posedge clk) begin
    if (rx_valid && !frame_start && state == idle) begin
      case (op_in)
        get_cookie:  tx_byte <= COOKIE;
        get_version: tx_byte <= {VERSION_MAJOR, VERSION_MINOR};
        abus_read:   tx_byte <= trs_addr[7:0];  // low byte only
        default:     tx_byte <= tx_byte;
      endcase
    end
  end

  assign param0 = params[0];
  assign param1 = params[1];
  assign param2 = params[2];

endmodule

`default_nettype wire

//--- hw/breakpoint_unit.sv
`default_nettype none

module breakpoint_unit #(
  parameter int NUM_BREAKPOINTS = 8
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 action,
  input  esp_cmd_pkg::esp_opcode_e             opcode,
  input  esp_cmd_pkg::esp_byte_t               param0,
  input  esp_cmd_pkg::esp_byte_t               param1,
  input  esp_cmd_pkg::esp_byte_t               param2,
  input  trs_bus_pkg::trs_addr_t               trs_addr,
  input  logic                                 trs_rd_n,
  output logic                                 bp_hit,
  output logic [$clog2(NUM_BREAKPOINTS)-1:0]   bp_index
);
  import esp_cmd_pkg::*;
  import trs_bus_pkg::*;

  localparam int IDX_W = $clog2(NUM_BREAKPOINTS);

  trs_addr_t                  bp_addr [NUM_BREAKPOINTS];
  logic [NUM_BREAKPOINTS-1:0] bp_active;
  logic                       bp_enabled;
  logic [IDX_W-1:0]           slot;      // slot named by param0
  logic                       match_any;
  logic [IDX_W-1:0]           match_idx;

  assign slot = param0[IDX_W-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      bp_active  <= '0;
      bp_enabled <= 1'b0;
    end else if (action) begin
      case (opcode)
        set_breakpoint:      bp_active[slot] <= 1'b1;
        clear_breakpoint:    bp_active[slot] <= 1'b0;
        enable_breakpoints:  bp_enabled <= 1'b1;
        disable_breakpoints: bp_enabled <= 1'b0;
        default: ;
      endcase
    end
  end

  // slot addresses, high byte in param2
  always_ff @(posedge clk) begin
    if (action && opcode == set_breakpoint) bp_addr[slot] <= {param2, param1};
  end

  // scan from the top so the lowest matching slot wins
  always_comb begin
    match_any = 1'b0;
    match_idx = '0;
    for (int i = NUM_BREAKPOINTS - 1; i >= 0; i--) begin
      if (bp_active[i] && bp_addr[i] == trs_addr) begin
        match_any = 1'b1;
        match_idx = IDX_W'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      bp_hit   <= 1'b0;
      bp_index <= '0;
    end else begin
      bp_hit <= !trs_rd_n && bp_enabled && match_any;  // memory reads only
      if (match_any) bp_index <= match_idx;
    end
  end

endmodule

`default_nettype wire

//--- hw/keyb_led_regs.sv
`default_nettype none

module keyb_led_regs (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     action,
  input  esp_cmd_pkg::esp_opcode_e opcode,
  input  esp_cmd_pkg::esp_byte_t   param0,
  input  esp_cmd_pkg::esp_byte_t   param1,
  output logic                     led_red,
  output logic                     led_green,
  output logic                     led_blue,
  output logic                     key_pressed
);
  import esp_cmd_pkg::*;
  import trs_bus_pkg::*;

  localparam int NUM_ROWS = 2 ** $bits(keyb_row_idx_t);

  keyb_row_t     matrix [NUM_ROWS];
  keyb_row_idx_t row;  // low bits of param0
  keyb_row_t     any_row;

  assign row = param0[$bits(keyb_row_idx_t)-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_ROWS; i++) matrix[i] <= '0;  // nothing pressed
      led_red   <= 1'b0;
      led_green <= 1'b0;
      led_blue  <= 1'b0;
    end else if (action) begin
      if (opcode == send_keyb) matrix[row] <= param1;
      if (opcode == set_led) begin
        led_red   <= param0[0];
        led_green <= param0[1];
        led_blue  <= param0[2];
      end
    end
  end

  // fold all rows together
  always_comb begin
    any_row = '0;
    for (int i = 0; i < NUM_ROWS; i++) any_row = any_row | matrix[i];
  end

  assign key_pressed = |any_row;

endmodule

`default_nettype wire

//--- hw/trs_io_top.sv
`default_nettype none

module trs_io_top #(
  parameter int NUM_BREAKPOINTS = 8
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               sck,
  input  logic                               cs_n,
  input  logic                               mosi,
  output logic                               miso,
  input  trs_bus_pkg::trs_addr_t             trs_addr,
  input  logic                               trs_rd_n,
  output logic                               led_red,
  output logic                               led_green,
  output logic                               led_blue,
  output logic                               key_pressed,
  output logic                               bp_hit,
  output logic [$clog2(NUM_BREAKPOINTS)-1:0] bp_index
);
  import esp_cmd_pkg::*;

  // spi link <-> parser
  esp_byte_t   rx_byte;
  logic        rx_valid;
  logic        frame_start;
  logic        tx_load;
  esp_byte_t   tx_byte;

  // parser -> targets
  logic        action;
  esp_opcode_e opcode;
  esp_byte_t   param0;
  esp_byte_t   param1;
  esp_byte_t   param2;

  spi_byte_link u_link (
    .clk         (clk),
    .rst         (rst),
    .sck         (sck),
    .cs_n        (cs_n),
    .mosi        (mosi),
    .miso        (miso),
    .tx_load     (tx_load),
    .tx_byte     (tx_byte),
    .rx_byte     (rx_byte),
    .rx_valid    (rx_valid),
    .frame_start (frame_start)
  );

  esp_cmd_parser u_parser (
    .clk         (clk),
    .rst         (rst),
    .rx_byte     (rx_byte),
    .rx_valid    (rx_valid),
    .frame_start (frame_start),
    .trs_addr    (trs_addr),  // for abus_read
    .action      (action),
    .opcode      (opcode),
    .param0      (param0),
    .param1      (param1),
    .param2      (param2),
    .tx_load     (tx_load),
    .tx_byte     (tx_byte)
  );

  breakpoint_unit #(
    .NUM_BREAKPOINTS (NUM_BREAKPOINTS)
  ) u_bp (
    .clk      (clk),
    .rst      (rst),
    .action   (action),
    .opcode   (opcode),
    .param0   (param0),
    .param1   (param1),
    .param2   (param2),
    .trs_addr (trs_addr),
    .trs_rd_n (trs_rd_n),
    .bp_hit   (bp_hit),
    .bp_index (bp_index)
  );

  keyb_led_regs u_regs (
    .clk         (clk),
    .rst         (rst),
    .action      (action),
    .opcode      (opcode),
    .param0      (param0),
    .param1      (param1),
    .led_red     (led_red),
    .led_green   (led_green),
    .led_blue    (led_blue),
    .key_pressed (key_pressed)
  );

endmodule

`default_nettype wire

//--- sim/trs_io_checker.sv
`default_nettype none

module trs_io_checker (
  input logic clk,
  input logic rst,
  input logic action,
  input logic trs_rd_n,
  input logic bp_hit,
  input logic key_pressed,
  input logic led_red,
  input logic led_green,
  input logic led_blue
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count;  // summed into the testbench verdict

  initial fail_count = 0;

  // one-cycle strobe from the parser
  action_single_cycle: assert property (@(posedge clk) disable iff (rst) action |=> !action)
    else begin
      fail_count++;
      $error("action stayed high for two cycles");
    end

  // a hit needs a memory read one edge earlier
  hit_needs_read: assert property (@(posedge clk) disable iff (rst) bp_hit |-> $past(!trs_rd_n))
    else begin
      fail_count++;
      $error("bp_hit high without a read on the previous cycle");
    end

  // target registers move only right after a command
  regs_change_after_action: assert property (@(posedge clk) disable iff (rst)
      !$stable({key_pressed, led_red, led_green, led_blue}) |-> $past(action))
    else begin
      fail_count++;
      $error("key_pressed or an LED changed without a preceding action");
    end

  outputs_clear_after_reset: assert property (@(posedge clk)
      $fell(rst) |-> !bp_hit && !key_pressed && !led_red && !led_green && !led_blue)
    else begin
      fail_count++;
      $error("bp_hit, key_pressed or an LED not low when reset ended");
    end

endmodule

// internal strobe comes from the top level scope
bind trs_io_top trs_io_checker u_checker (
  .clk         (clk),
  .rst         (rst),
  .action      (action),
  .trs_rd_n    (trs_rd_n),
  .bp_hit      (bp_hit),
  .key_pressed (key_pressed),
  .led_red     (led_red),
  .led_green   (led_green),
  .led_blue    (led_blue)
);

`default_nettype wire

//--- sim/trs_io_tb.sv
`default_nettype none

module trs_io_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import esp_cmd_pkg::*;
  import trs_bus_pkg::*;

  localparam int NUM_BP         = 8;
  localparam int IDX_W          = $clog2(NUM_BP);
  localparam int HALF           = 4;     // sck half period in clk
  localparam int GAP            = 6;     // idle clk between frames
  localparam int TIMEOUT_CYCLES = 6000;  // ~45 bytes of 64 clk plus margin

  localparam logic [7:0] EXP_COOKIE  = 8'haf;
  localparam logic [7:0] EXP_VERSION = {3'd0, 5'd3};  // major 0, minor 3

  logic             clk;
  logic             rst;
  logic             sck;
  logic             cs_n;
  logic             mosi;
  logic             miso;
  trs_addr_t        trs_addr;
  logic             trs_rd_n;
  logic             led_red;
  logic             led_green;
  logic             led_blue;
  logic             key_pressed;
  logic             bp_hit;
  logic [IDX_W-1:0] bp_index;

  integer seed;
  int     errors;
  int     errors_at_start;  // error count when the current test began
  int     tests_passed;
  int     tests_failed;
  int     cycle_count;

  trs_io_top #(
    .NUM_BREAKPOINTS (NUM_BP)
  ) dut (
    .clk         (clk),
    .rst         (rst),
    .sck         (sck),
    .cs_n        (cs_n),
    .mosi        (mosi),
    .miso        (miso),
    .trs_addr    (trs_addr),
    .trs_rd_n    (trs_rd_n),
    .led_red     (led_red),
    .led_green   (led_green),
    .led_blue    (led_blue),
    .key_pressed (key_pressed),
    .bp_hit      (bp_hit),
    .bp_index    (bp_index)
  );

  always #10 clk = ~clk;  // 20 ns

  task automatic check_val(input string name, input logic [15:0] expected,
                           input logic [15:0] actual);
    assert (actual === expected) else begin
      $display("[ERROR] %0.1f ns %s expected %0h actual %0h", $realtime, name, expected,
               actual);
      errors++;
    end
  endtask

  task automatic start_test();
    errors_at_start = errors;
  endtask

  task automatic finish_test(input string name);
    if (errors == errors_at_start) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d mismatches", name, errors - errors_at_start);
    end
  endtask

  task automatic begin_frame();
    @(posedge clk);
    cs_n <= 1'b0;
    repeat (2) @(posedge clk);  // let the link see cs_n first
  endtask

  // mode 0 msb first with miso read at mid-cycle before each rising sck
  task automatic spi_byte(input esp_byte_t tx, output esp_byte_t rx);
    for (int i = 7; i >= 0; i--) begin
      mosi <= tx[i];  // sck is low here
      repeat (HALF - 1) @(posedge clk);
      @(negedge clk);
      rx[i] = miso;
      @(posedge clk);
      sck <= 1'b1;
      repeat (HALF) @(posedge clk);
      sck <= 1'b0;
    end
  endtask

  // ends at a falling clk edge with outputs settled
  task automatic end_frame();
    repeat (HALF) @(posedge clk);
    cs_n <= 1'b1;
    repeat (GAP) @(posedge clk);
    @(negedge clk);
  endtask

  task automatic send_cmd(input esp_byte_t op, input int n, input esp_byte_t p0,
                          input esp_byte_t p1, input esp_byte_t p2);
    esp_byte_t unused;
    begin_frame();
    spi_byte(op, unused);
    if (n > 0) spi_byte(p0, unused);
    if (n > 1) spi_byte(p1, unused);
    if (n > 2) spi_byte(p2, unused);
    end_frame();
  endtask

  // opcode followed by a dummy byte that clocks the answer out
  task automatic read_response(input esp_byte_t op, output esp_byte_t resp);
    esp_byte_t unused;
    begin_frame();
    spi_byte(op, unused);
    spi_byte(8'h00, resp);  // dropped by the link while busy
    end_frame();
  endtask

  // hit is registered one edge after the bus cycle starts
  task automatic bus_cycle(input trs_addr_t addr, input logic rd_n, input logic exp_hit,
                           input logic [IDX_W-1:0] exp_idx);
    @(posedge clk);
    trs_addr <= addr;
    trs_rd_n <= rd_n;
    @(posedge clk);
    @(negedge clk);
    check_val("bp_hit", exp_hit, bp_hit);
    if (exp_hit) check_val("bp_index", exp_idx, bp_index);
    @(posedge clk);
    trs_rd_n <= 1'b1;
  endtask

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin : main
    esp_byte_t     rx;
    trs_addr_t     addr;
    esp_byte_t     led_val;
    keyb_row_idx_t row;
    keyb_row_t     keys;
    trs_addr_t     bp_addr;

    clk          = 1'b0;
    rst          = 1'b1;
    sck          = 1'b0;  // mode 0 idle
    cs_n         = 1'b1;
    mosi         = 1'b0;
    trs_addr     = '0;
    trs_rd_n     = 1'b1;
    seed         = 32'h69d9;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    repeat (2) @(posedge clk);

    start_test();
    read_response(get_cookie, rx);
    check_val("miso cookie", EXP_COOKIE, rx);
    read_response(get_version, rx);
    check_val("miso version", EXP_VERSION, rx);
    finish_test("get_cookie/get_version");

    start_test();
    addr = trs_addr_t'($random(seed));
    @(posedge clk);
    trs_addr <= addr;  // held for the whole frame
    read_response(abus_read, rx);
    check_val("miso abus low byte", addr[7:0], rx);
    finish_test("abus_read");

    start_test();
    led_val = esp_byte_t'($random(seed));
    send_cmd(set_led, 1, led_val, 8'h00, 8'h00);
    check_val("{led_blue,led_green,led_red}", led_val[2:0], {led_blue, led_green, led_red});
    led_val = ~led_val;  // every led flips on the second pass
    send_cmd(set_led, 1, led_val, 8'h00, 8'h00);
    check_val("{led_blue,led_green,led_red}", led_val[2:0], {led_blue, led_green, led_red});
    finish_test("set_led");

    start_test();
    row  = keyb_row_idx_t'($random(seed));
    keys = keyb_row_t'($random(seed)) | 8'h01;  // at least one key down
    send_cmd(send_keyb, 2, {5'd0, row}, keys, 8'h00);
    check_val("key_pressed", 1'b1, key_pressed);
    send_cmd(send_keyb, 2, {5'd0, row}, 8'h00, 8'h00);
    check_val("key_pressed", 1'b0, key_pressed);
    finish_test("send_keyb");

    start_test();
    bp_addr = trs_addr_t'($random(seed));
    send_cmd(set_breakpoint, 3, 8'd5, bp_addr[7:0], bp_addr[15:8]);
    send_cmd(set_breakpoint, 3, 8'd2, bp_addr[7:0], bp_addr[15:8]);
    send_cmd(enable_breakpoints, 0, 8'h00, 8'h00, 8'h00);
    bus_cycle(bp_addr, 1'b0, 1'b1, IDX_W'(2));  // lowest slot wins
    send_cmd(clear_breakpoint, 1, 8'd2, 8'h00, 8'h00);
    bus_cycle(bp_addr, 1'b0, 1'b1, IDX_W'(5));
    bus_cycle(bp_addr, 1'b1, 1'b0, '0);  // write cycle
    send_cmd(disable_breakpoints, 0, 8'h00, 8'h00, 8'h00);
    bus_cycle(bp_addr, 1'b0, 1'b0, '0);
    finish_test("breakpoints");

    $display("%0d tests passed, %0d tests failed, %0d checker assertion failures",
             tests_passed, tests_failed, dut.u_checker.fail_count);
    if (tests_failed == 0 && dut.u_checker.fail_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
hw/esp_cmd_pkg.sv
hw/trs_bus_pkg.sv
hw/spi_byte_link.sv
hw/esp_cmd_parser.sv
hw/breakpoint_unit.sv
hw/keyb_led_regs.sv
hw/trs_io_top.sv
sim/trs_io_checker.sv
sim/trs_io_tb.sv
